//--- Bender.yml
package:
  name: processor_ci

sources:
  # Harness RTL
  - files:
      - design/processor_ci_pkg.sv
      - design/core_wb_if.sv
      - design/reset_sequencer.sv
      - design/native_wb_bridge.sv
      - design/wb_memory.sv
      - design/processor_ci_top.sv

  # Verification sources
  - target: test
    files:
      - verif/processor_ci_sva.sv
      - verif/processor_ci_tb.sv

//--- design/core_wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface core_wb_if;

    logic                                cyc;
    logic                                stb;
    logic                                we;
    logic [processor_ci_pkg::STRB_W-1:0] sel;   // Byte lane select
    logic [processor_ci_pkg::ADDR_W-1:0] addr;
    logic [processor_ci_pkg::DATA_W-1:0] wdata;
    logic [processor_ci_pkg::DATA_W-1:0] rdata;
    logic                                ack;   // One-cycle pulse

    // Bridge side
    modport master (
        output cyc,
        output stb,
        output we,
        output sel,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    // Memory side
    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  sel,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

`default_nettype wire

//--- design/native_wb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module native_wb_bridge (
    input  logic                                clk_core,
    input  logic                                rst_i,
    input  logic                                mem_valid_i,
    input  logic [processor_ci_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic [processor_ci_pkg::DATA_W-1:0] mem_wdata_i,
    input  logic [processor_ci_pkg::STRB_W-1:0] mem_wstrb_i,
    output logic [processor_ci_pkg::DATA_W-1:0] mem_rdata_o,
    output logic                                mem_ready_o,
    core_wb_if.master                           wb
);

    localparam logic [1:0] ST_IDLE = 2'd0; // Waiting for a native request
    localparam logic [1:0] ST_BUS  = 2'd1; // Wishbone cycle open
    localparam logic [1:0] ST_RESP = 2'd2; // Ready pulse out, valid ignored

    logic [1:0]                          state_q;
    logic                                bus_active_q;
    logic                                we_q;
    logic [processor_ci_pkg::STRB_W-1:0] sel_q;
    logic [processor_ci_pkg::ADDR_W-1:0] addr_q;
    logic [processor_ci_pkg::DATA_W-1:0] wdata_q;
    logic                                accept;
    logic                                done;

    assign accept = (state_q == ST_IDLE) && mem_valid_i;
    assign done   = (state_q == ST_BUS) && wb.ack;

    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            state_q      <= ST_IDLE;
            bus_active_q <= 1'b0;
            mem_ready_o  <= 1'b0;
        end else begin
            mem_ready_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (mem_valid_i) begin
                        state_q <= ST_BUS;
                    end
                end
                ST_BUS: begin
                    if (wb.ack) begin
                        bus_active_q <= 1'b0;
                        mem_ready_o  <= 1'b1; // Registered copy of ack
                        state_q      <= ST_RESP;
                    end else begin
                        bus_active_q <= 1'b1; // Raised one cycle after capture
                    end
                end
                ST_RESP: begin
                    // Core still shows the old request here
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Request capture and response data
    always_ff @(posedge clk_core) begin
        if (accept) begin
            addr_q  <= mem_addr_i;
            wdata_q <= mem_wdata_i;
            we_q    <= |mem_wstrb_i;  // Any strobe means write
            sel_q   <= (mem_wstrb_i != '0) ? mem_wstrb_i : '1; // Reads take all lanes
        end
        if (done) begin
            mem_rdata_o <= wb.rdata;
        end
    end

    assign wb.cyc   = bus_active_q;
    assign wb.stb   = bus_active_q;
    assign wb.we    = we_q;
    assign wb.sel   = sel_q;
    assign wb.addr  = addr_q;
    assign wb.wdata = wdata_q;

endmodule

`default_nettype wire

//--- design/processor_ci_pkg.sv
`default_nettype none

package processor_ci_pkg;

    // Native and Wishbone bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8; // One strobe per byte lane

    // The address MSB selects the region
    localparam logic REGION_RAM  = 1'b0;
    localparam logic REGION_CTRL = 1'b1;

    // One bus address, seen as a raw word or split into its fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic              region;  // RAM or control space
            logic [ADDR_W-4:0] index;   // Word index, aliased by the memory
            logic [1:0]        offset;  // Byte offset within the word
        } fields;
    } bus_addr_u;

endpackage

`default_nettype wire

//--- design/processor_ci_top.sv
`timescale 1ns/1ps
`default_nettype none

module processor_ci_top #(
    parameter int                                  MEMORY_WORDS     = 1024,
    parameter int                                  RESET_CLK_CYCLES = 16,
    parameter logic [processor_ci_pkg::DATA_W-1:0] ID               = 32'h5043_4901
) (
    input  logic                                clk_core,
    input  logic                                rst_i,
    output logic                                core_rst_o,  // To the external core

    // Native memory port of the core
    input  logic                                mem_valid_i,
    input  logic [processor_ci_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic [processor_ci_pkg::DATA_W-1:0] mem_wdata_i,
    input  logic [processor_ci_pkg::STRB_W-1:0] mem_wstrb_i,
    output logic [processor_ci_pkg::DATA_W-1:0] mem_rdata_o,
    output logic                                mem_ready_o
);

    // Bridge to memory bus
    core_wb_if wb_bus ();

    // Stretched core reset
    reset_sequencer #(
        .RESET_CLK_CYCLES (RESET_CLK_CYCLES)
    ) u_reset_sequencer (
        .clk_core   (clk_core),
        .rst_i      (rst_i),
        .core_rst_o (core_rst_o)
    );

    native_wb_bridge u_native_wb_bridge (
        .clk_core    (clk_core),
        .rst_i       (rst_i),
        .mem_valid_i (mem_valid_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_wstrb_i (mem_wstrb_i),
        .mem_rdata_o (mem_rdata_o),
        .mem_ready_o (mem_ready_o),
        .wb          (wb_bus.master)
    );

    // Program and data words plus the ID region
    wb_memory #(
        .MEMORY_WORDS (MEMORY_WORDS),
        .ID           (ID)
    ) u_wb_memory (
        .clk_core (clk_core),
        .rst_i    (rst_i),
        .wb       (wb_bus.slave)
    );

endmodule

`default_nettype wire

//--- design/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
    parameter int RESET_CLK_CYCLES = 16
) (
    input  logic clk_core,
    input  logic rst_i,
    output logic core_rst_o
);

    // Wide enough to hold RESET_CLK_CYCLES itself
    localparam int CNT_W = (RESET_CLK_CYCLES > 0) ? $clog2(RESET_CLK_CYCLES + 1) : 1;

    logic [CNT_W-1:0] cnt_q;

    // Counter reloads during system reset and runs down afterwards
    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            cnt_q <= CNT_W'(RESET_CLK_CYCLES);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Core reset stays asserted until the count is exhausted
    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            core_rst_o <= 1'b1;
        end else begin
            core_rst_o <= (cnt_q != '0); // Falls on the edge that sees zero
        end
    end

endmodule

`default_nettype wire

//--- design/wb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module wb_memory #(
    parameter int                                  MEMORY_WORDS = 1024,
    parameter logic [processor_ci_pkg::DATA_W-1:0] ID           = 32'h5043_4901
) (
    input  logic     clk_core,
    input  logic     rst_i,
    core_wb_if.slave wb
);

    localparam int IDX_W = $clog2(MEMORY_WORDS);

    processor_ci_pkg::bus_addr_u         addr_u;
    logic [IDX_W-1:0]                    word_idx;
    logic                                ram_hit;
    logic                                ctrl_hit;
    logic                                access;
    logic                                ack_q;
    logic [processor_ci_pkg::DATA_W-1:0] rdata_q;
    logic [processor_ci_pkg::DATA_W-1:0] mem_q [MEMORY_WORDS];

    // Raw bus address into the union
    assign addr_u.raw = wb.addr;

    // Upper index bits are dropped so the RAM aliases modulo its size
    assign word_idx = addr_u.fields.index[IDX_W-1:0];

    always_comb begin
        ram_hit  = 1'b0;
        ctrl_hit = 1'b0;
        case (addr_u.fields.region)
            processor_ci_pkg::REGION_RAM:  ram_hit  = 1'b1;
            processor_ci_pkg::REGION_CTRL: ctrl_hit = 1'b1;
            default: begin
                ram_hit  = 1'b0;
                ctrl_hit = 1'b0;
            end
        endcase
    end

    // Only a fresh strobe is served, never the ack cycle itself
    assign access = wb.cyc && wb.stb && !ack_q;

    always_ff @(posedge clk_core) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // Byte-lane writes into RAM
    always_ff @(posedge clk_core) begin
        if (access && wb.we && ram_hit) begin
            for (int lane = 0; lane < processor_ci_pkg::STRB_W; lane++) begin
                if (wb.sel[lane]) begin
                    mem_q[word_idx][lane*8 +: 8] <= wb.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Read data lines up with the ack
    always_ff @(posedge clk_core) begin
        if (access) begin
            if (ctrl_hit) begin
                rdata_q <= ID;              // Control space is read-only
            end else begin
                rdata_q <= mem_q[word_idx]; // Word before any write this cycle
            end
        end
    end

    assign wb.ack   = ack_q;
    assign wb.rdata = rdata_q;

endmodule

`default_nettype wire

//--- files.f
design/processor_ci_pkg.sv
design/core_wb_if.sv
design/reset_sequencer.sv
design/native_wb_bridge.sv
design/wb_memory.sv
design/processor_ci_top.sv
verif/processor_ci_sva.sv
verif/processor_ci_tb.sv

//--- verif/processor_ci_sva.sv
`timescale 1ns/1ps
`default_nettype none

module processor_ci_sva (
    input logic                                clk_core,
    input logic                                rst_i,
    input logic                                cyc_i,
    input logic                                stb_i,
    input logic                                we_i,
    input logic [processor_ci_pkg::STRB_W-1:0] sel_i,
    input logic [processor_ci_pkg::ADDR_W-1:0] addr_i,
    input logic [processor_ci_pkg::DATA_W-1:0] wdata_i,
    input logic                                ack_i,
    input logic                                ready_i
);

    int assert_fails = 0;

    // Classic cycle closes on the edge after ack
    close_on_ack: assert property (@(posedge clk_core) disable iff (rst_i)
        ack_i |=> !(cyc_i || stb_i))
        else begin
            assert_fails++;
            $error("Wishbone cycle still open after ack");
        end

    // Request held until the slave acks
    req_stable: assert property (@(posedge clk_core) disable iff (rst_i)
        (stb_i && !ack_i) |=> (stb_i && $stable(addr_i) && $stable(wdata_i)
                               && $stable(sel_i) && $stable(we_i)))
        else begin
            assert_fails++;
            $error("Wishbone request changed before ack");
        end

    ready_pulse: assert property (@(posedge clk_core) disable iff (rst_i)
        ready_i |=> !ready_i)
        else begin
            assert_fails++;
            $error("mem_ready_o held longer than one cycle");
        end

    ready_after_ack: assert property (@(posedge clk_core) disable iff (rst_i)
        ack_i |=> ready_i)
        else begin
            assert_fails++;
            $error("mem_ready_o missing one cycle after ack");
        end

    ready_from_ack: assert property (@(posedge clk_core) disable iff (rst_i)
        ready_i |-> $past(ack_i))
        else begin
            assert_fails++;
            $error("mem_ready_o without an ack one cycle before");
        end

endmodule

bind native_wb_bridge processor_ci_sva u_processor_ci_sva (
    .clk_core (clk_core),
    .rst_i    (rst_i),
    .cyc_i    (wb.cyc),
    .stb_i    (wb.stb),
    .we_i     (wb.we),
    .sel_i    (wb.sel),
    .addr_i   (wb.addr),
    .wdata_i  (wb.wdata),
    .ack_i    (wb.ack),
    .ready_i  (mem_ready_o)
);

`default_nettype wire

//--- verif/processor_ci_tb.sv
`timescale 1ns/1ps
`default_nettype none

module processor_ci_tb;

    localparam int          TB_MEMORY_WORDS = 1024;
    localparam int          TB_RESET_CYCLES = 16;
    localparam logic [31:0] TB_ID           = 32'h5043_4901;
    localparam int          RESET_LEN       = 5;   // System reset cycles
    localparam int          N_ROWS          = 24;
    localparam logic        OP_RD           = 1'b0;
    localparam logic        OP_WR           = 1'b1;
    // Reset, core reset tail, five cycles per row and some slack
    localparam int          TIMEOUT = RESET_LEN + TB_RESET_CYCLES + 5 * N_ROWS + 40;

    logic                                clk_core;
    logic                                rst_i;
    logic                                core_rst_o;
    logic                                mem_valid_i;
    logic [processor_ci_pkg::ADDR_W-1:0] mem_addr_i;
    logic [processor_ci_pkg::DATA_W-1:0] mem_wdata_i;
    logic [processor_ci_pkg::STRB_W-1:0] mem_wstrb_i;
    logic [processor_ci_pkg::DATA_W-1:0] mem_rdata_o;
    logic                                mem_ready_o;

    // Stimulus table
    logic                                row_op    [N_ROWS];
    logic [processor_ci_pkg::ADDR_W-1:0] row_addr  [N_ROWS];
    logic [processor_ci_pkg::DATA_W-1:0] row_data  [N_ROWS];  // Expected value on fixed reads
    logic [processor_ci_pkg::STRB_W-1:0] row_strb  [N_ROWS];
    logic                                row_fixed [N_ROWS];
    logic                                row_b2b   [N_ROWS];  // Valid held from previous row
    int                                  n_rows;

    logic [processor_ci_pkg::DATA_W-1:0] ref_mem [TB_MEMORY_WORDS]; // Reference RAM
    int data_errs;
    int bit_errs;
    int count_errs;
    int other_errs;
    int sva_errs;
    int ready_pulses;
    int cycle_cnt;
    int seed;

    processor_ci_top u_processor_ci_top (
        .clk_core    (clk_core),
        .rst_i       (rst_i),
        .core_rst_o  (core_rst_o),
        .mem_valid_i (mem_valid_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wdata_i (mem_wdata_i),
        .mem_wstrb_i (mem_wstrb_i),
        .mem_rdata_o (mem_rdata_o),
        .mem_ready_o (mem_ready_o)
    );

    always #5 clk_core = ~clk_core;

    // Every ready pulse is seen at exactly one falling edge
    always @(negedge clk_core) begin
        if (mem_ready_o === 1'b1) ready_pulses++;
    end

    always @(posedge clk_core) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Run timed out after %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_data(input string name, input logic [processor_ci_pkg::DATA_W-1:0] got,
                              input logic [processor_ci_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            data_errs++;
            $display("** Error at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errs++;
            $display("** Error at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errs++;
            $display("** Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic logic [processor_ci_pkg::ADDR_W-1:0] make_addr(input logic region,
                                                                      input int index,
                                                                      input int offset);
        processor_ci_pkg::bus_addr_u a;
        a.fields.region = region;
        a.fields.index  = (processor_ci_pkg::ADDR_W-3)'(index);
        a.fields.offset = 2'(offset);
        return a.raw;
    endfunction

    // Control space reads the ID, RAM aliases modulo its size
    function automatic logic [processor_ci_pkg::DATA_W-1:0] model_read(
            input logic [processor_ci_pkg::ADDR_W-1:0] addr);
        processor_ci_pkg::bus_addr_u a;
        a.raw = addr;
        if (a.fields.region == processor_ci_pkg::REGION_CTRL) return TB_ID;
        return ref_mem[a.fields.index % TB_MEMORY_WORDS];
    endfunction

    task automatic model_write(input logic [processor_ci_pkg::ADDR_W-1:0] addr,
                               input logic [processor_ci_pkg::DATA_W-1:0] data,
                               input logic [processor_ci_pkg::STRB_W-1:0] strb);
        processor_ci_pkg::bus_addr_u a;
        int idx;
        a.raw = addr;
        idx   = a.fields.index % TB_MEMORY_WORDS;
        if (a.fields.region == processor_ci_pkg::REGION_RAM) begin
            for (int lane = 0; lane < processor_ci_pkg::STRB_W; lane++) begin
                if (strb[lane]) ref_mem[idx][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    endtask

    task automatic add_row(input logic op, input logic [processor_ci_pkg::ADDR_W-1:0] addr,
                           input logic [processor_ci_pkg::DATA_W-1:0] data,
                           input logic [processor_ci_pkg::STRB_W-1:0] strb,
                           input logic fixed, input logic b2b);
        if (n_rows >= N_ROWS) begin
            other_errs++;
            $display("Stimulus table has more rows than its size of %0d", N_ROWS);
        end else begin
            row_op[n_rows]    = op;
            row_addr[n_rows]  = addr;
            row_data[n_rows]  = data;
            row_strb[n_rows]  = strb;
            row_fixed[n_rows] = fixed;
            row_b2b[n_rows]   = b2b;
            n_rows++;
        end
    endtask

    task automatic build_table();
        add_row(OP_WR, make_addr(0, 5, 0), 32'h1234_5678, 4'hf, 0, 0);
        add_row(OP_RD, make_addr(0, 5, 0), '0, '0, 0, 0);
        add_row(OP_WR, make_addr(0, 6, 0), 32'ha5a5_a5a5, 4'hf, 0, 0);
        add_row(OP_WR, make_addr(0, 6, 0), 32'h0000_bb00, 4'b0010, 0, 0); // Lane merging
        add_row(OP_WR, make_addr(0, 6, 0), 32'hcc00_0000, 4'b1000, 0, 0);
        add_row(OP_RD, make_addr(0, 6, 0), '0, '0, 0, 0);
        add_row(OP_WR, make_addr(0, 0, 0), 32'h0bad_f00d, 4'hf, 0, 0);
        add_row(OP_RD, make_addr(1, 0, 0), TB_ID, '0, 1, 0);
        add_row(OP_WR, make_addr(1, 0, 0), 32'hdead_beef, 4'hf, 0, 0); // Ignored by the memory
        add_row(OP_RD, make_addr(1, 0, 0), TB_ID, '0, 1, 0);
        add_row(OP_RD, make_addr(1, 3, 2), TB_ID, '0, 1, 0);
        add_row(OP_RD, make_addr(0, 0, 0), '0, '0, 0, 0);               // Same index as control write
        add_row(OP_WR, make_addr(0, 9, 0), $urandom(), 4'hf, 0, 0);
        add_row(OP_RD, make_addr(0, 9 + TB_MEMORY_WORDS, 0), '0, '0, 0, 0);
        add_row(OP_WR, make_addr(0, 17 + 2 * TB_MEMORY_WORDS, 0), $urandom(), 4'hf, 0, 0);
        add_row(OP_RD, make_addr(0, 17, 0), '0, '0, 0, 0);
        // Back-to-back burst with valid never dropped
        add_row(OP_WR, make_addr(0, 40, 0), $urandom(), 4'hf, 0, 0);
        add_row(OP_WR, make_addr(0, 41, 0), $urandom(), 4'hf, 0, 1);
        add_row(OP_WR, make_addr(0, 41, 0), $urandom(), 4'b0101, 0, 1);
        add_row(OP_RD, make_addr(0, 40, 0), '0, '0, 0, 1);
        add_row(OP_RD, make_addr(0, 41, 3), '0, '0, 0, 1);
        add_row(OP_RD, make_addr(0, 40 + 3 * TB_MEMORY_WORDS, 0), '0, '0, 0, 1);
        add_row(OP_WR, make_addr(0, 5 + TB_MEMORY_WORDS, 0), $urandom(), 4'b1100, 0, 1);
        add_row(OP_RD, make_addr(0, 5, 0), '0, '0, 0, 1);
    endtask

    // Plays the core for one request, called on a falling edge
    task automatic run_row(input int i);
        int                                  lat;
        int                                  exp_lat;
        logic [processor_ci_pkg::DATA_W-1:0] exp_data;
        mem_valid_i = 1'b1;
        mem_addr_i  = row_addr[i];
        mem_wdata_i = (row_op[i] == OP_WR) ? row_data[i] : '0;
        mem_wstrb_i = (row_op[i] == OP_WR) ? row_strb[i] : '0;
        // Acceptance edge plus three, one more when the bridge skips valid
        exp_lat = row_b2b[i] ? 5 : 4;
        lat     = 0;
        do begin
            @(posedge clk_core);
            @(negedge clk_core);
            lat++;
        end while (mem_ready_o !== 1'b1);
        check_count($sformatf("ready latency (row %0d)", i), lat, exp_lat);
        if (row_op[i] == OP_RD) begin
            exp_data = row_fixed[i] ? row_data[i] : model_read(row_addr[i]);
            check_data($sformatf("mem_rdata_o (row %0d)", i), mem_rdata_o, exp_data);
        end else begin
            model_write(row_addr[i], row_data[i], row_strb[i]);
        end
        if (i + 1 < N_ROWS && row_b2b[i + 1]) return;
        mem_valid_i = 1'b0;
        mem_wstrb_i = '0;
        @(posedge clk_core);
        @(negedge clk_core);
        check_bit("mem_ready_o", mem_ready_o, 1'b0); // Single-cycle pulse
    endtask

    initial begin
        clk_core     = 1'b0;
        rst_i        = 1'b1;
        mem_valid_i  = 1'b0;
        mem_addr_i   = '0;
        mem_wdata_i  = '0;
        mem_wstrb_i  = '0;
        data_errs    = 0;
        bit_errs     = 0;
        count_errs   = 0;
        other_errs   = 0;
        ready_pulses = 0;
        cycle_cnt    = 0;
        n_rows       = 0;
        seed         = 32'h5e26;
        void'($urandom(seed));
        build_table();
        if (n_rows != N_ROWS) begin
            other_errs++;
            $display("Stimulus table holds %0d rows instead of %0d", n_rows, N_ROWS);
        end

        repeat (RESET_LEN) begin
            @(posedge clk_core);
            @(negedge clk_core);
            check_bit("core_rst_o", core_rst_o, 1'b1);
            check_bit("mem_ready_o", mem_ready_o, 1'b0);
        end
        rst_i = 1'b0;

        // Core reset stretch, falls after the last counted edge
        for (int k = 1; k <= TB_RESET_CYCLES + 1; k++) begin
            @(posedge clk_core);
            @(negedge clk_core);
            check_bit("core_rst_o", core_rst_o, k <= TB_RESET_CYCLES);
        end
        repeat (3) begin
            @(posedge clk_core);
            @(negedge clk_core);
            check_bit("core_rst_o", core_rst_o, 1'b0);
        end

        for (int i = 0; i < N_ROWS; i++) begin
            run_row(i);
        end

        check_bit("core_rst_o", core_rst_o, 1'b0);
        check_count("ready pulses", ready_pulses, N_ROWS);
        sva_errs = u_processor_ci_top.u_native_wb_bridge.u_processor_ci_sva.assert_fails;
        $display("Summary: %0d data, %0d bit, %0d count, %0d other, %0d assertion errors",
                 data_errs, bit_errs, count_errs, other_errs, sva_errs);
        if (data_errs + bit_errs + count_errs + other_errs + sva_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
